/* kt_pkg.sv */
`default_nettype none

package kt_pkg;

  ////////////////////////////////////////////////////////////
  // Timing
  ////////////////////////////////////////////////////////////

  // Clock cycles per serial bit, shared by receiver and transmitter
  localparam int unsigned BAUD_DIV = 16;

  // A gyro calibration keeps the sequencer busy this many cycles
  localparam int unsigned CAL_CYCLES = 64;

  // Travel time for one square of the board
  localparam int unsigned SQUARE_CYCLES = 32;

  // Counter widths follow from the cycle counts above
  localparam int unsigned BAUD_CNT_W = $clog2(BAUD_DIV);
  localparam int unsigned CAL_CNT_W = $clog2(CAL_CYCLES);
  localparam int unsigned SQ_CNT_W = $clog2(SQUARE_CYCLES);

  ////////////////////////////////////////////////////////////
  // Command word fields
  ////////////////////////////////////////////////////////////

  // Opcodes sit in bits 15 to 12 of the command word
  localparam logic [3:0] OP_CAL_GYRO = 4'h2;
  localparam logic [3:0] OP_MOVE = 4'h4;
  localparam logic [3:0] OP_MOVE_FANFARE = 4'h5;

  // Heading codes sit in bits 11 to 4, every other code is refused
  localparam logic [7:0] HDG_NORTH = 8'h00;
  localparam logic [7:0] HDG_WEST = 8'h3F;
  localparam logic [7:0] HDG_SOUTH = 8'h7F;
  localparam logic [7:0] HDG_EAST = 8'hBF;

  // Compact direction code passed from the sequencer to the board model
  localparam logic [1:0] DIR_NORTH = 2'd0;
  localparam logic [1:0] DIR_WEST = 2'd1;
  localparam logic [1:0] DIR_SOUTH = 2'd2;
  localparam logic [1:0] DIR_EAST = 2'd3;

  ////////////////////////////////////////////////////////////
  // Board, sequencer states and replies
  ////////////////////////////////////////////////////////////

  // Squares per side, legal coordinates run from 0 to BOARD_SIZE-1
  localparam int unsigned BOARD_SIZE = 5;
  localparam logic [2:0] START_XX = 3'd0;
  localparam logic [2:0] START_YY = 3'd4;

  // Move sequencer states
  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_CAL = 2'd1;
  localparam logic [1:0] ST_MOVE = 2'd2;
  localparam logic [1:0] ST_REPLY = 2'd3;

  // Reply bytes returned over the serial line
  localparam logic [7:0] RESP_ACK = 8'hA5;
  localparam logic [7:0] RESP_NACK = 8'hEE;

endpackage

`default_nettype wire

/* uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx import kt_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       rx,
  output logic [7:0] rx_byte,
  output logic       rx_valid
);

  logic                  rx_meta;
  logic                  rx_sync;
  logic                  rx_prev;
  logic                  active;
  logic [3:0]            bit_cnt;
  logic [BAUD_CNT_W-1:0] baud_cnt;
  logic                  bit_end;
  logic [7:0]            shift;

  // Two flop synchronizer, plus one more flop to see the falling edge
  // The line idles high so the flops come out of reset high
  always_ff @(posedge clk) begin
    if (reset) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  // End of a full bit period, measured from the middle of the start bit
  assign bit_end = active && (bit_cnt != 4'd0) && (baud_cnt == BAUD_CNT_W'(BAUD_DIV - 1));

  ////////////////////////////////////////////////////////////
  // Frame control
  ////////////////////////////////////////////////////////////

  // bit_cnt is 0 for the start bit, 1 to 8 for data and 9 for the stop bit
  always_ff @(posedge clk) begin
    if (reset) begin
      active   <= 1'b0;
      bit_cnt  <= 4'd0;
      baud_cnt <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (!active) begin
        if (rx_prev && !rx_sync) begin
          active   <= 1'b1;
          bit_cnt  <= 4'd0;
          baud_cnt <= '0;
        end
      end else if (bit_cnt == 4'd0) begin
        // Half a bit in, the start bit must still be low or it was a glitch
        if (baud_cnt == BAUD_CNT_W'(BAUD_DIV / 2 - 1)) begin
          baud_cnt <= '0;
          if (rx_sync) begin
            active <= 1'b0;
          end else begin
            bit_cnt <= 4'd1;
          end
        end else begin
          baud_cnt <= baud_cnt + BAUD_CNT_W'(1);
        end
      end else if (bit_end) begin
        baud_cnt <= '0;
        if (bit_cnt == 4'd9) begin
          // A low stop bit is a framing error and the byte is dropped
          active   <= 1'b0;
          rx_valid <= rx_sync;
        end else begin
          bit_cnt <= bit_cnt + 4'd1;
        end
      end else begin
        baud_cnt <= baud_cnt + BAUD_CNT_W'(1);
      end
    end
  end

  // Data arrives LSB first, so shift in from the top
  always_ff @(posedge clk) begin
    if (bit_end && (bit_cnt != 4'd9)) begin
      shift <= {rx_sync, shift[7:1]};
    end
  end

  assign rx_byte = shift;

endmodule

`default_nettype wire

/* cmd_assembler.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_assembler (
  input  logic        clk,
  input  logic        reset,
  input  logic [7:0]  rx_byte,
  input  logic        rx_valid,
  output logic [15:0] cmd,
  output logic        cmd_rdy
);

  // Set while the high byte is held and the low byte is awaited
  logic       half;
  logic [7:0] high_byte;

  // Control side of the assembler
  always_ff @(posedge clk) begin
    if (reset) begin
      half    <= 1'b0;
      cmd_rdy <= 1'b0;
    end else begin
      cmd_rdy <= 1'b0;
      if (rx_valid) begin
        // The second byte completes the word, so the flag toggles per byte
        half    <= ~half;
        cmd_rdy <= half;
      end
    end
  end

  // The high byte comes first on the line
  always_ff @(posedge clk) begin
    if (rx_valid && !half) begin
      high_byte <= rx_byte;
    end
  end

  // Word register, updated together with the ready pulse
  always_ff @(posedge clk) begin
    if (rx_valid && half) begin
      cmd <= {high_byte, rx_byte};
    end
  end

endmodule

`default_nettype wire

/* board_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module board_tracker import kt_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic [1:0] move_dir,
  input  logic [3:0] move_squares,
  input  logic       step,
  output logic [2:0] xx,
  output logic [2:0] yy,
  output logic       move_legal
);

  // Landing coordinate for moves that count upward
  logic [4:0] north_reach;
  logic [4:0] east_reach;

  assign north_reach = {2'b00, yy} + {1'b0, move_squares};
  assign east_reach = {2'b00, xx} + {1'b0, move_squares};

  // The knight must land inside 0 to 4 on the axis of travel
  // The other axis does not change during a straight move
  always_comb begin
    case (move_dir)
      DIR_NORTH: move_legal = north_reach <= 5'(BOARD_SIZE - 1);
      DIR_WEST:  move_legal = move_squares <= {1'b0, xx};
      DIR_SOUTH: move_legal = move_squares <= {1'b0, yy};
      default:   move_legal = east_reach <= 5'(BOARD_SIZE - 1);
    endcase
  end

  // One square per step pulse. North and east count up
  always_ff @(posedge clk) begin
    if (reset) begin
      xx <= START_XX;
      yy <= START_YY;
    end else if (step) begin
      case (move_dir)
        DIR_NORTH: yy <= yy + 3'd1;
        DIR_WEST:  xx <= xx - 3'd1;
        DIR_SOUTH: yy <= yy - 3'd1;
        default:   xx <= xx + 3'd1;
      endcase
    end
  end

endmodule

`default_nettype wire

/* move_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module move_sequencer import kt_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic [15:0] cmd,
  input  logic        cmd_rdy,
  input  logic        move_legal,
  output logic [1:0]  move_dir,
  output logic [3:0]  move_squares,
  output logic        step,
  output logic        moving,
  output logic        fanfare,
  output logic        cal_done,
  output logic [7:0]  resp_byte,
  output logic        resp_send
);

  logic [3:0]           opcode;
  logic [7:0]           heading;
  logic [3:0]           count;
  logic [1:0]           hdg_dir;
  logic                 hdg_known;
  logic                 is_move;
  logic                 accept;
  logic [1:0]           state;
  logic [1:0]           dir_q;
  logic [3:0]           squares_left;
  logic [CAL_CNT_W-1:0] cal_cnt;
  logic [SQ_CNT_W-1:0]  sq_cnt;

  // Field split of the command word
  assign opcode = cmd[15:12];
  assign heading = cmd[11:4];
  assign count = cmd[3:0];

  // Only the four cardinal heading codes are understood
  always_comb begin
    hdg_known = 1'b1;
    case (heading)
      HDG_NORTH: hdg_dir = DIR_NORTH;
      HDG_WEST:  hdg_dir = DIR_WEST;
      HDG_SOUTH: hdg_dir = DIR_SOUTH;
      HDG_EAST:  hdg_dir = DIR_EAST;
      default: begin
        hdg_dir   = DIR_NORTH;
        hdg_known = 1'b0;
      end
    endcase
  end

  // While idle the board model judges the incoming word directly
  // During a move the step direction comes from the latched heading
  assign move_dir = (state == ST_IDLE) ? hdg_dir : dir_q;

  // Only the idle decision reads move_legal, so the count comes from the incoming word
  assign move_squares = count;

  // The incoming command is decided in its cmd_rdy cycle
  assign is_move = (opcode == OP_MOVE) || (opcode == OP_MOVE_FANFARE);
  assign accept = (opcode == OP_CAL_GYRO) ||
                  (is_move && cal_done && hdg_known && (count != 4'd0) && move_legal);

  ////////////////////////////////////////////////////////////
  // Sequencer FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= ST_IDLE;
      moving       <= 1'b0;
      fanfare      <= 1'b0;
      cal_done     <= 1'b0;
      step         <= 1'b0;
      resp_send    <= 1'b0;
      squares_left <= 4'd0;
      cal_cnt      <= '0;
      sq_cnt       <= '0;
    end else begin
      step      <= 1'b0;
      resp_send <= 1'b0;
      case (state)
        ST_IDLE: begin
          // Commands are only looked at here, so a busy sequencer drops them
          if (cmd_rdy) begin
            if (!accept) begin
              resp_send <= 1'b1;
            end else if (opcode == OP_CAL_GYRO) begin
              state   <= ST_CAL;
              cal_cnt <= '0;
            end else begin
              state        <= ST_MOVE;
              moving       <= 1'b1;
              fanfare      <= (opcode == OP_MOVE_FANFARE);
              squares_left <= count;
              sq_cnt       <= '0;
            end
          end
        end
        ST_CAL: begin
          // Calibration flag stays set until the next reset
          if (cal_cnt == CAL_CNT_W'(CAL_CYCLES - 1)) begin
            cal_done  <= 1'b1;
            resp_send <= 1'b1;
            state     <= ST_IDLE;
          end else begin
            cal_cnt <= cal_cnt + CAL_CNT_W'(1);
          end
        end
        ST_MOVE: begin
          if (sq_cnt == SQ_CNT_W'(SQUARE_CYCLES - 1)) begin
            step         <= 1'b1;
            sq_cnt       <= '0;
            squares_left <= squares_left - 4'd1;
            if (squares_left == 4'd1) begin
              state <= ST_REPLY;
            end
          end else begin
            sq_cnt <= sq_cnt + SQ_CNT_W'(1);
          end
        end
        default: begin
          // One cycle after the last step the move is closed and acknowledged
          moving    <= 1'b0;
          fanfare   <= 1'b0;
          resp_send <= 1'b1;
          state     <= ST_IDLE;
        end
      endcase
    end
  end

  // Reply byte and direction are captured with the decision
  always_ff @(posedge clk) begin
    if ((state == ST_IDLE) && cmd_rdy) begin
      resp_byte <= accept ? RESP_ACK : RESP_NACK;
      dir_q     <= hdg_dir;
    end
  end

endmodule

`default_nettype wire

/* uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx import kt_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic [7:0] resp_byte,
  input  logic       resp_send,
  output logic       tx,
  output logic       tx_busy
);

  logic [3:0]            bit_cnt;
  logic [BAUD_CNT_W-1:0] baud_cnt;
  logic                  bit_end;
  logic                  load;

  // Remaining frame bits after the start bit: data LSB first, then stop
  logic [8:0]            shift;

  // A request during a frame is not expected and is ignored
  assign load = resp_send && !tx_busy;
  assign bit_end = tx_busy && (baud_cnt == BAUD_CNT_W'(BAUD_DIV - 1));

  ////////////////////////////////////////////////////////////
  // Frame control
  ////////////////////////////////////////////////////////////

  // bit_cnt tracks the bit on the line, 0 is start and 9 is stop
  always_ff @(posedge clk) begin
    if (reset) begin
      tx       <= 1'b1;
      tx_busy  <= 1'b0;
      bit_cnt  <= 4'd0;
      baud_cnt <= '0;
    end else if (load) begin
      tx       <= 1'b0;
      tx_busy  <= 1'b1;
      bit_cnt  <= 4'd0;
      baud_cnt <= '0;
    end else if (bit_end) begin
      baud_cnt <= '0;
      if (bit_cnt == 4'd9) begin
        // Stop bit has been held a full period, line stays high
        tx_busy <= 1'b0;
        tx      <= 1'b1;
      end else begin
        tx      <= shift[0];
        bit_cnt <= bit_cnt + 4'd1;
      end
    end else if (tx_busy) begin
      baud_cnt <= baud_cnt + BAUD_CNT_W'(1);
    end
  end

  // Shifting in ones keeps the tail of the frame at the stop level
  always_ff @(posedge clk) begin
    if (load) begin
      shift <= {1'b1, resp_byte};
    end else if (bit_end) begin
      shift <= {1'b1, shift[8:1]};
    end
  end

endmodule

`default_nettype wire

/* knights_tour_cmd.sv */
`timescale 1ns/1ps
`default_nettype none

module knights_tour_cmd (
  input  logic       clk,
  input  logic       reset,
  input  logic       rx,
  output logic       tx,
  output logic       moving,
  output logic       fanfare,
  output logic       cal_done,
  output logic [2:0] xx,
  output logic [2:0] yy
);

  // Receive side
  logic [7:0]  rx_byte;
  logic        rx_valid;
  logic [15:0] cmd;
  logic        cmd_rdy;

  // Sequencer to board model
  logic [1:0]  move_dir;
  logic [3:0]  move_squares;
  logic        move_legal;
  logic        step;

  // Reply path
  logic [7:0]  resp_byte;
  logic        resp_send;

  ////////////////////////////////////////////////////////////
  // Command pipeline
  ////////////////////////////////////////////////////////////

  uart_rx u_uart_rx (
    .clk      (clk),
    .reset    (reset),
    .rx       (rx),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid)
  );

  cmd_assembler u_cmd_assembler (
    .clk      (clk),
    .reset    (reset),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid),
    .cmd      (cmd),
    .cmd_rdy  (cmd_rdy)
  );

  move_sequencer u_move_sequencer (
    .clk          (clk),
    .reset        (reset),
    .cmd          (cmd),
    .cmd_rdy      (cmd_rdy),
    .move_legal   (move_legal),
    .move_dir     (move_dir),
    .move_squares (move_squares),
    .step         (step),
    .moving       (moving),
    .fanfare      (fanfare),
    .cal_done     (cal_done),
    .resp_byte    (resp_byte),
    .resp_send    (resp_send)
  );

  board_tracker u_board_tracker (
    .clk          (clk),
    .reset        (reset),
    .move_dir     (move_dir),
    .move_squares (move_squares),
    .step         (step),
    .xx           (xx),
    .yy           (yy),
    .move_legal   (move_legal)
  );

  // The sequencer never replies twice within one frame, so busy stays local
  uart_tx u_uart_tx (
    .clk       (clk),
    .reset     (reset),
    .resp_byte (resp_byte),
    .resp_send (resp_send),
    .tx        (tx),
    .tx_busy   ()
  );

endmodule

`default_nettype wire

/* knights_tour_cmd_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module knights_tour_cmd_tb import kt_pkg::*; ();

  // Command counts drive the run budget below
  localparam int NUM_FIXED = 12;
  localparam int NUM_RANDOM = 60;

  // Budget per command covers two frames in, the longest legal move and one frame out
  localparam int CMD_CYCLES = 20 * BAUD_DIV + 4 * SQUARE_CYCLES + 10 * BAUD_DIV + 8;
  localparam int TIMEOUT_CYCLES =
    3 * ((NUM_FIXED + NUM_RANDOM) * CMD_CYCLES + CAL_CYCLES + 16) / 2;

  logic       clk;
  logic       reset;
  logic       rx;
  logic       tx;
  logic       moving;
  logic       fanfare;
  logic       cal_done;
  logic [2:0] xx;
  logic [2:0] yy;

  // Queues hold the expected {reply, cal flag, xx, yy} per command and the decoded replies
  logic [14:0] exp_q[$];
  logic [7:0]  reply_q[$];
  int          checked_cnt = 0;
  int          cycle_cnt = 0;
  int          fanfare_cycles = 0;
  integer      seed = 32'hb5ef;

  // Reference model state after the last queued command
  logic        model_cal;
  logic [2:0]  model_xx;
  logic [2:0]  model_yy;

  knights_tour_cmd u_knights_tour_cmd (
    .clk      (clk),
    .reset    (reset),
    .rx       (rx),
    .tx       (tx),
    .moving   (moving),
    .fanfare  (fanfare),
    .cal_done (cal_done),
    .xx       (xx),
    .yy       (yy)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Failure reporting and compare tasks
  ////////////////////////////////////////////////////////////

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic check_resp(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (exp !== act) begin
      fail_run($sformatf("FAILED %s expected %h got %h", name, exp, act));
    end
  endtask

  task automatic check_pos(input string name, input logic [2:0] exp, input logic [2:0] act);
    if (exp !== act) begin
      fail_run($sformatf("FAILED %s expected %h got %h", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      fail_run($sformatf("FAILED %s expected %h got %h", name, exp, act));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Returns {reply, calibrated, new xx, new yy} for one command word
  function automatic logic [14:0] ref_model(input logic cal, input logic [2:0] cur_x,
                                            input logic [2:0] cur_y, input logic [15:0] word);
    logic [3:0] op;
    logic [7:0] hdg;
    logic       known;
    int         n;
    int         dx;
    int         dy;
    int         nx;
    int         ny;
    op = word[15:12];
    hdg = word[11:4];
    n = word[3:0];
    known = 1'b1;
    dx = 0;
    dy = 0;
    // North and east count up, west and south count down
    case (hdg)
      HDG_NORTH: dy = 1;
      HDG_WEST:  dx = -1;
      HDG_SOUTH: dy = -1;
      HDG_EAST:  dx = 1;
      default:   known = 1'b0;
    endcase
    nx = cur_x + dx * n;
    ny = cur_y + dy * n;
    if (op == OP_CAL_GYRO) begin
      return {RESP_ACK, 1'b1, cur_x, cur_y};
    end
    if ((op != OP_MOVE) && (op != OP_MOVE_FANFARE)) begin
      return {RESP_NACK, cal, cur_x, cur_y};
    end
    if (!cal || !known || (n == 0)) begin
      return {RESP_NACK, cal, cur_x, cur_y};
    end
    if ((nx < 0) || (nx > BOARD_SIZE - 1) || (ny < 0) || (ny > BOARD_SIZE - 1)) begin
      return {RESP_NACK, cal, cur_x, cur_y};
    end
    return {RESP_ACK, cal, 3'(nx), 3'(ny)};
  endfunction

  // Counts the cycles the sequencer stays busy with an accepted command
  function automatic int work_cycles(input logic [14:0] exp, input logic [15:0] word);
    if (exp[14:7] != RESP_ACK) begin
      return 0;
    end
    if (word[15:12] == OP_CAL_GYRO) begin
      return CAL_CYCLES;
    end
    return word[3:0] * SQUARE_CYCLES;
  endfunction

  ////////////////////////////////////////////////////////////
  // Serial driver and command helpers
  ////////////////////////////////////////////////////////////

  // Sends an 8N1 frame LSB first and holds each bit BAUD_DIV cycles from a falling edge
  task automatic send_byte(input logic [7:0] data);
    int i;
    rx = 1'b0;
    repeat (BAUD_DIV) @(negedge clk);
    for (i = 0; i < 8; i++) begin
      rx = data[i];
      repeat (BAUD_DIV) @(negedge clk);
    end
    rx = 1'b1;
    repeat (BAUD_DIV) @(negedge clk);
  endtask

  task automatic send_cmd(input logic [15:0] word);
    send_byte(word[15:8]);
    send_byte(word[7:0]);
  endtask

  // Pushes the expected outcome and moves the model forward
  task automatic queue_expect(input logic [15:0] word, output int work);
    logic [14:0] exp;
    exp = ref_model(model_cal, model_xx, model_yy, word);
    exp_q.push_back(exp);
    model_cal = exp[6];
    model_xx = exp[5:3];
    model_yy = exp[2:0];
    work = work_cycles(exp, word);
  endtask

  // Allows 40 bit times beyond the expected work for the reply to show up
  task automatic wait_replies(input int target, input int work);
    int waited;
    waited = 0;
    while (checked_cnt < target) begin
      @(negedge clk);
      waited++;
      if (waited > work + 40 * BAUD_DIV) begin
        fail_run("The reply never arrived on the tx line");
      end
    end
  endtask

  task automatic run_cmd(input logic [15:0] word);
    int work;
    int target;
    queue_expect(word, work);
    target = checked_cnt + 1;
    send_cmd(word);
    wait_replies(target, work);
  endtask

  // Second word goes out on the line while the first move is running
  task automatic run_overlap(input logic [15:0] first, input logic [15:0] second);
    int work1;
    int work2;
    int target;
    queue_expect(first, work1);
    queue_expect(second, work2);
    target = checked_cnt + 2;
    send_cmd(first);
    check_flag("moving", 1'b1, moving);
    send_cmd(second);
    wait_replies(target, work1 + work2);
  endtask

  ////////////////////////////////////////////////////////////
  // Monitors
  ////////////////////////////////////////////////////////////

  // Reply decoder that samples tx near the middle of each bit
  initial begin : tx_monitor
    logic [7:0] data;
    int         i;
    forever begin
      @(negedge clk);
      if (!reset && (tx === 1'b0)) begin
        repeat (BAUD_DIV / 2) @(negedge clk);
        for (i = 0; i < 8; i++) begin
          repeat (BAUD_DIV) @(negedge clk);
          data[i] = tx;
        end
        repeat (BAUD_DIV) @(negedge clk);
        if (tx !== 1'b1) begin
          fail_run("A reply frame on tx had a low stop bit");
        end
        reply_q.push_back(data);
      end
    end
  end

  // Each reply is matched against the oldest expectation
  initial begin : compare_replies
    logic [7:0]  got;
    logic [14:0] exp;
    forever begin
      @(negedge clk);
      if (reply_q.size() != 0) begin
        got = reply_q.pop_front();
        if (exp_q.size() == 0) begin
          fail_run("A reply arrived although no command was waiting for one");
        end else begin
          exp = exp_q.pop_front();
          check_resp("resp_byte", exp[14:7], got);
          check_pos("xx", exp[5:3], xx);
          check_pos("yy", exp[2:0], yy);
          check_flag("cal_done", exp[6], cal_done);
          check_flag("moving", 1'b0, moving);
          check_flag("fanfare", 1'b0, fanfare);
          checked_cnt++;
        end
      end
    end
  end

  always @(negedge clk) begin
    if (fanfare) begin
      fanfare_cycles++;
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      fail_run($sformatf("Timeout, the test did not finish in %0d cycles", TIMEOUT_CYCLES));
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin : stimulus
    logic [15:0] word;
    logic [7:0]  hdg;
    logic [3:0]  cnt;
    int          r;
    int          k;
    int          fan_before;
    reset = 1'b1;
    rx = 1'b1;
    model_cal = 1'b0;
    model_xx = START_XX;
    model_yy = START_YY;
    repeat (16) @(negedge clk);
    reset = 1'b0;
    check_pos("xx", START_XX, xx);
    check_pos("yy", START_YY, yy);
    check_flag("cal_done", 1'b0, cal_done);

    // Moves are refused until the gyro has been calibrated
    run_cmd(16'h4BF1);
    check_pos("xx", 3'd0, xx);
    check_pos("yy", 3'd4, yy);
    run_cmd({OP_CAL_GYRO, 12'h000});
    check_flag("cal_done", 1'b1, cal_done);

    // East one square, then south two with fanfare
    fan_before = fanfare_cycles;
    run_cmd(16'h4BF1);
    check_flag("fanfare", 1'b0, fanfare_cycles != fan_before);
    run_cmd(16'h57F2);
    check_flag("fanfare", 1'b1, fanfare_cycles != fan_before);
    check_pos("xx", 3'd1, xx);
    check_pos("yy", 3'd2, yy);

    // Three moves off the board, then a bad heading, a zero count and a bad opcode
    run_cmd(16'h4003);
    run_cmd(16'h43F2);
    run_cmd(16'h47F3);
    run_cmd(16'h4121);
    run_cmd(16'h4BF0);
    run_cmd(16'h7BF1);

    // Random walk with counts up to five, so many moves fall off the edge
    for (k = 0; k < NUM_RANDOM; k++) begin
      r = $random(seed);
      case (r[2:1])
        2'd0:    hdg = HDG_NORTH;
        2'd1:    hdg = HDG_WEST;
        2'd2:    hdg = HDG_SOUTH;
        default: hdg = HDG_EAST;
      endcase
      if (r[7:3] == 5'd0) begin
        hdg = r[15:8];
      end
      cnt = r[19:16] % 4'd6;
      word = {(r[0] ? OP_MOVE_FANFARE : OP_MOVE), hdg, cnt};
      run_cmd(word);
    end

    // Two squares toward the centre while a zero count word follows on the line
    if (model_xx <= 3'd2) begin
      word = {OP_MOVE, HDG_EAST, 4'd2};
    end else begin
      word = {OP_MOVE, HDG_WEST, 4'd2};
    end
    run_overlap(word, {OP_MOVE, HDG_NORTH, 4'd0});

    repeat (4) @(negedge clk);
    if ((exp_q.size() != 0) || (reply_q.size() != 0)) begin
      fail_run("Replies and expected results were left unmatched");
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* all.f */
kt_pkg.sv
uart_rx.sv
cmd_assembler.sv
board_tracker.sv
move_sequencer.sv
uart_tx.sv
knights_tour_cmd.sv
knights_tour_cmd_tb.sv

/* Bender.yml */
package:
  name: knights_tour_cmd

sources:
  - kt_pkg.sv
  - uart_rx.sv
  - cmd_assembler.sv
  - board_tracker.sv
  - move_sequencer.sv
  - uart_tx.sv
  - knights_tour_cmd.sv
  - target: test
    files:
      - knights_tour_cmd_tb.sv
